// ==== design/dma_bus_pkg.sv ====
package dma_bus_pkg;

  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned RegAddrWidth = 8;
  localparam int unsigned WordBytes    = DataWidth / 8;

  typedef logic [AddrWidth-1:0]    addr_t;
  typedef logic [DataWidth-1:0]    data_t;
  typedef logic [RegAddrWidth-1:0] reg_addr_t;

  // Register bus served in the same cycle
  typedef struct packed {
    logic      valid;
    logic      write;
    reg_addr_t addr;   // Byte offset
    data_t     wdata;
  } reg_req_t;

  typedef struct packed {
    logic  ready;
    data_t rdata;
  } reg_rsp_t;

  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    data_t wdata;
  } mem_req_t;

  // Read data returns in acceptance order and writes get no response
  typedef struct packed {
    logic  ready;
    logic  rvalid;
    data_t rdata;
  } mem_rsp_t;

endpackage

// ==== design/dma_copy_backend.sv ====
module dma_copy_backend
  import dma_bus_pkg::*;
  import dma_desc_pkg::*;
#(
  parameter int unsigned BufferDepth = 4
) (
  input  logic       clk_i,
  input  logic       rst_i,
  input  burst_req_t burst_req_i,
  input  logic       valid_i,
  output logic       ready_o,
  output mem_req_t   mem_req_o,
  input  mem_rsp_t   mem_rsp_i,
  output logic       idle_o,
  output logic       tx_complete_o
);

  localparam int unsigned PtrWidth = $clog2(BufferDepth);
  localparam int unsigned CntWidth = $clog2(BufferDepth + 1);

  typedef logic [PtrWidth-1:0] ptr_t;
  typedef logic [CntWidth-1:0] cnt_t;

  logic              busy_q;
  logic              complete_q;
  logic              prio_q;       // High gives writes priority
  logic              lock_q;
  logic              lock_write_q;
  addr_t             rd_addr_q;
  addr_t             wr_addr_q;
  num_words_t        rd_left_q;
  num_words_t        wr_left_q;
  ptr_t              push_ptr_q;
  ptr_t              pop_ptr_q;
  cnt_t              fill_q;       // Words held in the buffer
  cnt_t              out_q;        // Reads accepted but not returned
  logic [CntWidth:0] inflight;
  data_t             buf_q [BufferDepth];
  logic              accept;
  logic              read_pend;
  logic              write_pend;
  logic              sel_write;
  logic              rd_acc;
  logic              wr_acc;
  logic              push;

  assign ready_o       = !busy_q;
  assign idle_o        = !busy_q && !complete_q;
  assign tx_complete_o = complete_q;
  assign accept        = valid_i && ready_o;

  assign inflight   = {1'b0, fill_q} + {1'b0, out_q};
  assign read_pend  = busy_q && (rd_left_q != '0) &&
                      (inflight < (CntWidth + 1)'(BufferDepth));
  assign write_pend = (fill_q != '0);

  // A stalled request keeps its slot
  assign sel_write = lock_q ? lock_write_q : (write_pend && (!read_pend || prio_q));

  always_comb begin
    mem_req_o.valid = read_pend || write_pend;
    mem_req_o.write = sel_write;
    mem_req_o.addr  = sel_write ? wr_addr_q : rd_addr_q;
    mem_req_o.wdata = buf_q[pop_ptr_q];
  end

  assign rd_acc = mem_req_o.valid && !sel_write && mem_rsp_i.ready;
  assign wr_acc = mem_req_o.valid && sel_write && mem_rsp_i.ready;
  assign push   = mem_rsp_i.rvalid;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q       <= 1'b0;
      complete_q   <= 1'b0;
      prio_q       <= 1'b0;
      lock_q       <= 1'b0;
      lock_write_q <= 1'b0;
      rd_left_q    <= '0;
      wr_left_q    <= '0;
      push_ptr_q   <= '0;
      pop_ptr_q    <= '0;
      fill_q       <= '0;
      out_q        <= '0;
    end else begin
      complete_q   <= 1'b0;
      lock_q       <= mem_req_o.valid && !mem_rsp_i.ready;
      lock_write_q <= sel_write;
      if (accept) begin
        rd_left_q  <= burst_req_i.num_words;
        wr_left_q  <= burst_req_i.num_words;
        busy_q     <= (burst_req_i.num_words != '0);
        complete_q <= (burst_req_i.num_words == '0); // Empty transfer
      end
      if (rd_acc) begin
        rd_left_q <= rd_left_q - num_words_t'(1);
      end
      if (wr_acc) begin
        wr_left_q <= wr_left_q - num_words_t'(1);
        pop_ptr_q <= pop_ptr_q + ptr_t'(1);
        if (wr_left_q == num_words_t'(1)) begin
          busy_q     <= 1'b0;
          complete_q <= 1'b1;
        end
      end
      if (push) begin
        push_ptr_q <= push_ptr_q + ptr_t'(1);
      end
      if (mem_req_o.valid && mem_rsp_i.ready) begin
        prio_q <= !sel_write;
      end
      fill_q <= fill_q + cnt_t'(push) - cnt_t'(wr_acc);
      out_q  <= out_q + cnt_t'(rd_acc) - cnt_t'(push);
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rd_addr_q <= burst_req_i.src;
      wr_addr_q <= burst_req_i.dst;
    end else begin
      if (rd_acc) begin
        rd_addr_q <= rd_addr_q + addr_t'(WordBytes);
      end
      if (wr_acc) begin
        wr_addr_q <= wr_addr_q + addr_t'(WordBytes);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      buf_q[push_ptr_q] <= mem_rsp_i.rdata;
    end
  end

  a_rvalid_expected: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_rsp_i.rvalid |-> (out_q != '0));

endmodule

// ==== design/dma_desc_frontend.sv ====
module dma_desc_frontend
  import dma_bus_pkg::*;
  import dma_desc_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  reg_req_t   reg_req_i,
  output reg_rsp_t   reg_rsp_o,
  output mem_req_t   mem_req_o,
  input  mem_rsp_t   mem_rsp_i,
  output burst_req_t be_req_o,
  output logic       be_valid_o,
  input  logic       be_ready_i,
  input  logic       be_tx_complete_i,
  input  logic       be_idle_i,
  output logic       irq_o
);

  fe_state_e  state_q;
  logic       busy_q;
  logic       irq_q;
  addr_t      desc_addr_q;
  data_t      done_cnt_q;
  desc_idx_t  req_idx_q;
  desc_idx_t  rsp_idx_q;
  burst_req_t burst_q;
  addr_t      next_q;
  logic       start_chain;

  assign start_chain = reg_req_i.valid && reg_req_i.write &&
                       (reg_req_i.addr == RegDescAddr) && !busy_q;

  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.rdata = '0;
    if (reg_req_i.valid && !reg_req_i.write) begin
      case (reg_req_i.addr)
        RegDescAddr:  reg_rsp_o.rdata = desc_addr_q;
        RegStatus:    reg_rsp_o.rdata = {30'b0, be_idle_i, busy_q};
        RegDoneCount: reg_rsp_o.rdata = done_cnt_q;
        default:      reg_rsp_o.rdata = '0;
      endcase
    end
  end

  always_comb begin
    mem_req_o = '0;
    if (state_q == FE_FETCH_REQ) begin
      mem_req_o.valid = 1'b1;
      mem_req_o.addr  = desc_addr_q + addr_t'(req_idx_q) * addr_t'(WordBytes);
    end else if (state_q == FE_WRITEBACK) begin
      mem_req_o.valid = 1'b1;
      mem_req_o.write = 1'b1;
      mem_req_o.addr  = desc_addr_q + DescNumOffset;
      mem_req_o.wdata = DescDoneMarker;
    end
  end

  assign be_req_o   = burst_q;
  assign be_valid_o = (state_q == FE_LAUNCH);
  assign irq_o      = irq_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= FE_IDLE;
      busy_q      <= 1'b0;
      irq_q       <= 1'b0;
      desc_addr_q <= '0;
      done_cnt_q  <= '0;
      req_idx_q   <= '0;
      rsp_idx_q   <= '0;
    end else begin
      irq_q <= 1'b0;
      if (mem_rsp_i.rvalid) begin
        rsp_idx_q <= rsp_idx_q + desc_idx_t'(1); // Wraps to zero after the last word
      end
      case (state_q)
        FE_FETCH_REQ: begin
          if (mem_rsp_i.ready) begin
            req_idx_q <= req_idx_q + desc_idx_t'(1);
            if (req_idx_q == DescIdxNext) begin
              state_q <= FE_FETCH_WAIT;
            end
          end
        end
        FE_FETCH_WAIT: begin
          if (mem_rsp_i.rvalid && (rsp_idx_q == DescIdxNext)) begin
            state_q <= FE_LAUNCH;
          end
        end
        FE_LAUNCH: begin
          if (be_ready_i) begin
            state_q <= FE_WAIT_DONE;
          end
        end
        FE_WAIT_DONE: begin
          if (be_tx_complete_i) begin
            state_q <= FE_WRITEBACK;
          end
        end
        FE_WRITEBACK: begin
          if (mem_rsp_i.ready) begin
            irq_q      <= 1'b1;
            done_cnt_q <= done_cnt_q + data_t'(1);
            busy_q     <= (next_q != '0); // End of chain drops busy with the irq
            state_q    <= FE_NEXT;
          end
        end
        FE_NEXT: begin
          if (busy_q) begin
            desc_addr_q <= next_q;
            state_q     <= FE_FETCH_REQ;
          end else begin
            state_q <= FE_IDLE;
          end
        end
        default: state_q <= FE_IDLE;
      endcase
      if (start_chain) begin
        desc_addr_q <= reg_req_i.wdata;
        busy_q      <= 1'b1;
        state_q     <= FE_FETCH_REQ;
      end
    end
  end

  // Descriptor words in fetch order
  always_ff @(posedge clk_i) begin
    if (mem_rsp_i.rvalid) begin
      case (rsp_idx_q)
        DescIdxSrc: burst_q.src <= mem_rsp_i.rdata;
        DescIdxDst: burst_q.dst <= mem_rsp_i.rdata;
        DescIdxNum: burst_q.num_words <= num_words_t'(mem_rsp_i.rdata);
        default:    next_q <= mem_rsp_i.rdata;
      endcase
    end
  end

  a_be_valid_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    be_valid_o && !be_ready_i |=> be_valid_o && $stable(be_req_o));

  a_irq_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
    irq_o |=> !irq_o);

endmodule

// ==== design/dma_desc_pkg.sv ====
package dma_desc_pkg;

  import dma_bus_pkg::*;

  typedef logic [15:0] num_words_t;

  localparam int unsigned DescWords = 4;

  typedef logic [$clog2(DescWords)-1:0] desc_idx_t;

  // Word order inside a descriptor
  localparam desc_idx_t DescIdxSrc  = desc_idx_t'(0);
  localparam desc_idx_t DescIdxDst  = desc_idx_t'(1);
  localparam desc_idx_t DescIdxNum  = desc_idx_t'(2);
  localparam desc_idx_t DescIdxNext = desc_idx_t'(3);

  localparam addr_t DescNumOffset  = 32'h8; // Byte offset of num_words
  localparam data_t DescDoneMarker = '1;

  localparam reg_addr_t RegDescAddr  = 8'h00;
  localparam reg_addr_t RegStatus    = 8'h04;
  localparam reg_addr_t RegDoneCount = 8'h08;

  typedef struct packed {
    addr_t      src;
    addr_t      dst;
    num_words_t num_words;
  } burst_req_t;

  typedef enum logic [2:0] {
    FE_IDLE,
    FE_FETCH_REQ,
    FE_FETCH_WAIT,
    FE_LAUNCH,
    FE_WAIT_DONE,
    FE_WRITEBACK,
    FE_NEXT
  } fe_state_e;

endpackage

// ==== design/dma_desc_top.sv ====
module dma_desc_top
  import dma_bus_pkg::*;
  import dma_desc_pkg::*;
#(
  parameter int unsigned BufferDepth   = 4, // Power of two
  parameter int unsigned ReadFifoDepth = 4
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  reg_req_t reg_req_i,
  output reg_rsp_t reg_rsp_o,
  output mem_req_t mem_req_o,
  input  mem_rsp_t mem_rsp_i,
  output logic     irq_o
);

  mem_req_t   fe_mem_req;
  mem_rsp_t   fe_mem_rsp;
  mem_req_t   be_mem_req;
  mem_rsp_t   be_mem_rsp;
  burst_req_t be_req;
  logic       be_valid;
  logic       be_ready;
  logic       be_tx_complete;
  logic       be_idle;

  dma_desc_frontend i_frontend (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .reg_req_i       (reg_req_i),
    .reg_rsp_o       (reg_rsp_o),
    .mem_req_o       (fe_mem_req),
    .mem_rsp_i       (fe_mem_rsp),
    .be_req_o        (be_req),
    .be_valid_o      (be_valid),
    .be_ready_i      (be_ready),
    .be_tx_complete_i(be_tx_complete),
    .be_idle_i       (be_idle),
    .irq_o           (irq_o)
  );

  dma_copy_backend #(
    .BufferDepth(BufferDepth)
  ) i_backend (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .burst_req_i  (be_req),
    .valid_i      (be_valid),
    .ready_o      (be_ready),
    .mem_req_o    (be_mem_req),
    .mem_rsp_i    (be_mem_rsp),
    .idle_o       (be_idle),
    .tx_complete_o(be_tx_complete)
  );

  dma_mem_arbiter #(
    .ReadFifoDepth(ReadFifoDepth)
  ) i_arbiter (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .fe_req_i (fe_mem_req),
    .fe_rsp_o (fe_mem_rsp),
    .be_req_i (be_mem_req),
    .be_rsp_o (be_mem_rsp),
    .mem_req_o(mem_req_o),
    .mem_rsp_i(mem_rsp_i)
  );

endmodule

// ==== design/dma_mem_arbiter.sv ====
module dma_mem_arbiter
  import dma_bus_pkg::*;
#(
  parameter int unsigned ReadFifoDepth = 4
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  mem_req_t fe_req_i,
  output mem_rsp_t fe_rsp_o,
  input  mem_req_t be_req_i,
  output mem_rsp_t be_rsp_o,
  output mem_req_t mem_req_o,
  input  mem_rsp_t mem_rsp_i
);

  localparam int unsigned PtrWidth = (ReadFifoDepth > 1) ? $clog2(ReadFifoDepth) : 1;
  localparam int unsigned CntWidth = $clog2(ReadFifoDepth + 1);

  typedef logic [PtrWidth-1:0] ptr_t;
  typedef logic [CntWidth-1:0] cnt_t;

  logic     sel_be;      // High grants the backend
  logic     lock_q;
  logic     lock_be_q;
  logic     last_be_q;
  mem_req_t gnt_req;
  logic     fifo_full;
  logic     accept;
  logic     push;
  logic     pop;
  logic     head_be;
  ptr_t     wr_ptr_q;
  ptr_t     rd_ptr_q;
  cnt_t     cnt_q;
  logic     owner_q [ReadFifoDepth];

  always_comb begin
    if (lock_q) begin
      sel_be = lock_be_q;
    end else if (fe_req_i.valid && be_req_i.valid) begin
      sel_be = !last_be_q;
    end else begin
      sel_be = be_req_i.valid;
    end
  end

  assign gnt_req   = sel_be ? be_req_i : fe_req_i;
  assign fifo_full = (cnt_q == cnt_t'(ReadFifoDepth));

  always_comb begin
    mem_req_o       = gnt_req;
    mem_req_o.valid = gnt_req.valid && (gnt_req.write || !fifo_full);
  end

  assign accept  = mem_req_o.valid && mem_rsp_i.ready;
  assign push    = accept && !gnt_req.write;
  assign pop     = mem_rsp_i.rvalid;
  assign head_be = owner_q[rd_ptr_q];

  always_comb begin
    fe_rsp_o.ready  = accept && !sel_be;
    fe_rsp_o.rvalid = pop && !head_be;
    fe_rsp_o.rdata  = mem_rsp_i.rdata;
    be_rsp_o.ready  = accept && sel_be;
    be_rsp_o.rvalid = pop && head_be;
    be_rsp_o.rdata  = mem_rsp_i.rdata;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lock_q    <= 1'b0;
      lock_be_q <= 1'b0;
      last_be_q <= 1'b0;
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      cnt_q     <= '0;
    end else begin
      lock_q    <= gnt_req.valid && !accept; // Also holds a read blocked by a full FIFO
      lock_be_q <= sel_be;
      if (accept) begin
        last_be_q <= sel_be;
      end
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(ReadFifoDepth - 1)) ? '0 : wr_ptr_q + ptr_t'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(ReadFifoDepth - 1)) ? '0 : rd_ptr_q + ptr_t'(1);
      end
      cnt_q <= cnt_q + cnt_t'(push) - cnt_t'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      owner_q[wr_ptr_q] <= sel_be;
    end
  end

  a_fifo_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
    cnt_q <= cnt_t'(ReadFifoDepth));

  a_fifo_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
    pop |-> (cnt_q != '0));

endmodule

// ==== project.f ====
design/dma_bus_pkg.sv
design/dma_desc_pkg.sv
design/dma_desc_frontend.sv
design/dma_copy_backend.sv
design/dma_mem_arbiter.sv
design/dma_desc_top.sv
verification/dma_mem_model.sv
verification/tb_dma_desc_top.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f project.f \
  --top-module tb_dma_desc_top -o sim_dma

out=$(./obj_dir/sim_dma || true)
echo "$out"
echo "$out" | grep -qx "Test OK"

// ==== verification/dma_mem_model.sv ====
module dma_mem_model
  import dma_bus_pkg::*;
#(
  parameter int unsigned MemWords = 1024,
  parameter int unsigned LogDepth = 256
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     stall_i,
  input  mem_req_t load_i,   // Backdoor preload that is not logged
  input  mem_req_t req_i,
  output mem_rsp_t rsp_o
);

  localparam int unsigned IdxWidth = $clog2(MemWords);
  localparam int unsigned LogWidth = $clog2(LogDepth);

  data_t       mem_q [MemWords];
  addr_t       log_addr_q [LogDepth];
  data_t       log_data_q [LogDepth];
  int unsigned log_cnt_q;
  logic        rvalid_q;
  data_t       rdata_q;
  logic        accept;

  assign accept       = req_i.valid && !stall_i;
  assign rsp_o.ready  = !stall_i;
  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q  <= 1'b0;
      log_cnt_q <= 0;
    end else begin
      rvalid_q <= accept && !req_i.write; // One cycle read latency
      if (accept && !req_i.write) begin
        rdata_q <= mem_q[req_i.addr[IdxWidth+1:2]];
      end
      if (accept && req_i.write) begin
        mem_q[req_i.addr[IdxWidth+1:2]] <= req_i.wdata;
        if (log_cnt_q < LogDepth) begin
          log_addr_q[log_cnt_q[LogWidth-1:0]] <= req_i.addr;
          log_data_q[log_cnt_q[LogWidth-1:0]] <= req_i.wdata;
        end
        log_cnt_q <= log_cnt_q + 1;
      end
    end
    if (load_i.valid) begin
      mem_q[load_i.addr[IdxWidth+1:2]] <= load_i.wdata;
    end
  end

  function automatic data_t peek(input addr_t addr);
    return mem_q[addr[IdxWidth+1:2]];
  endfunction

  // Logged bus writes with lo <= addr < hi
  function automatic int unsigned writes_in(input addr_t lo, input addr_t hi);
    int unsigned n;
    n = 0;
    for (int i = 0; i < LogDepth; i++) begin
      if ((i < int'(log_cnt_q)) && (log_addr_q[i[LogWidth-1:0]] >= lo) &&
          (log_addr_q[i[LogWidth-1:0]] < hi)) begin
        n++;
      end
    end
    return n;
  endfunction

endmodule

// ==== verification/tb_dma_desc_top.sv ====
module tb_dma_desc_top
  import dma_bus_pkg::*;
  import dma_desc_pkg::*;
;

  localparam int IrqTimeout  = 4000; // Cycles
  localparam int IdleTimeout = 200;  // Status reads

  logic        clk = 1'b0;
  logic        rst;
  logic        stall = 1'b0;
  reg_req_t    reg_req;
  reg_rsp_t    reg_rsp;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp;
  mem_req_t    load;
  logic        irq;
  logic [31:0] rng_state = 32'h96dd;
  logic        chain_armed;
  int          irq_cnt;
  logic        chk_en;
  string       chk_name;
  data_t       chk_exp;
  data_t       chk_act;
  int          errors = 0;
  int          proto_errs = 0;
  int          checks = 0;
  int          tests = 0;
  int          timeouts = 0;

  always #10 clk = ~clk;

  dma_desc_top #(
    .BufferDepth  (4),
    .ReadFifoDepth(4)
  ) uut (
    .clk_i    (clk),
    .rst_i    (rst),
    .reg_req_i(reg_req),
    .reg_rsp_o(reg_rsp),
    .mem_req_o(mem_req),
    .mem_rsp_i(mem_rsp),
    .irq_o    (irq)
  );

  dma_mem_model i_mem (
    .clk_i  (clk),
    .rst_i  (rst),
    .stall_i(stall),
    .load_i (load),
    .req_i  (mem_req),
    .rsp_o  (mem_rsp)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Source words derived from the full byte address
  function automatic data_t pattern(input addr_t addr);
    return (addr * 32'h9e37_79b1) ^ 32'h0f1e_2d3c;
  endfunction

  always @(posedge clk) begin
    rng_state = lcg_next(rng_state);
    stall <= (rng_state[17:16] == 2'b00); // Roughly one stall in four
  end

  always @(posedge clk) begin
    if (rst) begin
      irq_cnt <= 0;
    end else if (irq) begin
      irq_cnt <= irq_cnt + 1;
    end
  end

  a_value: assert property (@(posedge clk) chk_en |-> (chk_act == chk_exp))
    else begin
      $display("Fail %0t %s expected %h got %h", $time, chk_name, chk_exp, chk_act);
      errors++;
    end

  a_mem_hold: assert property (@(posedge clk) disable iff (rst)
    mem_req.valid && !mem_rsp.ready |=> mem_req.valid && $stable(mem_req.write) &&
      $stable(mem_req.addr) && (!mem_req.write || $stable(mem_req.wdata)))
    else begin
      $display("At %0t the memory request changed while it was stalled", $time);
      errors++;
      proto_errs++;
    end

  a_irq_quiet: assert property (@(posedge clk) disable iff (rst) !chain_armed |-> !irq)
    else begin
      $display("At %0t irq_o went high before any chain was started", $time);
      errors++;
      proto_errs++;
    end

  a_reg_ready: assert property (@(posedge clk) disable iff (rst)
    reg_req.valid |-> reg_rsp.ready)
    else begin
      $display("At %0t a register request got no ready in its own cycle", $time);
      errors++;
    end

  task automatic reg_access(input logic wr, input reg_addr_t addr, input data_t wdata,
                            output data_t rdata);
    @(posedge clk);
    reg_req <= '{valid: 1'b1, write: wr, addr: addr, wdata: wdata};
    if (wr && (addr == RegDescAddr)) begin
      chain_armed <= 1'b1;
    end
    @(negedge clk);
    rdata = reg_rsp.rdata;
    @(posedge clk);
    reg_req <= '0;
  endtask

  task automatic launch_chain(input addr_t desc_addr);
    data_t unused_rdata;
    reg_access(1'b1, RegDescAddr, desc_addr, unused_rdata);
  endtask

  task automatic load_word(input addr_t addr, input data_t data);
    @(posedge clk);
    load <= '{valid: 1'b1, write: 1'b1, addr: addr, wdata: data};
  endtask

  task automatic load_idle();
    @(posedge clk);
    load <= '0;
  endtask

  task automatic put_desc(input addr_t base, input addr_t src, input addr_t dst,
                          input data_t num, input addr_t next);
    load_word(base, src);
    load_word(base + 32'h4, dst);
    load_word(base + 32'h8, num);
    load_word(base + 32'hc, next);
    load_idle();
  endtask

  task automatic fill_src(input addr_t src, input int n);
    for (int i = 0; i < n; i++) begin
      load_word(src + addr_t'(4 * i), pattern(src + addr_t'(4 * i)));
    end
    load_idle();
  endtask

  task automatic check_value(input string name, input data_t exp, input data_t act);
    @(posedge clk);
    chk_en   <= 1'b1;
    chk_name <= name;
    chk_exp  <= exp;
    chk_act  <= act;
    checks++;
    @(posedge clk); // a_value samples here
    chk_en <= 1'b0;
  endtask

  task automatic wait_irqs(input int target);
    int n;
    n = 0;
    while ((timeouts == 0) && (irq_cnt < target) && (n < IrqTimeout)) begin
      @(negedge clk);
      n++;
    end
    if ((timeouts == 0) && (irq_cnt < target)) begin
      $display("Timeout at %0t waiting for irq_o, saw %0d of %0d pulses",
               $time, irq_cnt, target);
      timeouts++;
    end
  endtask

  task automatic wait_idle();
    data_t st;
    int    n;
    st = 32'h1;
    n  = 0;
    while ((timeouts == 0) && st[0] && (n < IdleTimeout)) begin
      reg_access(1'b0, RegStatus, '0, st);
      n++;
    end
    if ((timeouts == 0) && st[0]) begin
      $display("Timeout at %0t waiting for the busy bit to fall", $time);
      timeouts++;
    end
  endtask

  task automatic report_test(input string name, input int err0);
    @(negedge clk);
    tests++;
    $display("%s: %0d errors", name, errors - err0);
  endtask

  task automatic copy_single_desc();
    int err0;
    int base;
    err0 = errors;
    base = irq_cnt;
    put_desc(32'h000, 32'h100, 32'h200, 32'd8, 32'h000);
    fill_src(32'h100, 8);
    launch_chain(32'h000);
    wait_irqs(base + 1);
    wait_idle();
    if (timeouts == 0) begin
      for (int i = 0; i < 8; i++) begin
        check_value("dst_word", pattern(32'h100 + addr_t'(4 * i)),
                    i_mem.peek(32'h200 + addr_t'(4 * i)));
      end
    end
    report_test("single copy", err0);
  endtask

  task automatic walk_desc_chain();
    int    err0;
    int    base;
    data_t cnt0;
    data_t cnt1;
    data_t st;
    err0 = errors;
    base = irq_cnt;
    put_desc(32'h040, 32'h300, 32'h400, 32'd5, 32'h050);
    put_desc(32'h050, 32'h320, 32'h440, 32'd3, 32'h060);
    put_desc(32'h060, 32'h340, 32'h480, 32'd6, 32'h000);
    fill_src(32'h300, 5);
    fill_src(32'h320, 3);
    fill_src(32'h340, 6);
    reg_access(1'b0, RegDoneCount, '0, cnt0);
    launch_chain(32'h040);
    wait_irqs(base + 3);
    wait_idle();
    if (timeouts == 0) begin
      reg_access(1'b0, RegStatus, '0, st);
      reg_access(1'b0, RegDoneCount, '0, cnt1);
      check_value("irq_count", data_t'(base + 3), data_t'(irq_cnt));
      for (int i = 0; i < 3; i++) begin
        check_value("desc_num_word", DescDoneMarker, i_mem.peek(32'h048 + addr_t'(16 * i)));
      end
      check_value("status_busy", '0, {31'b0, st[0]});
      check_value("status_idle", 32'd1, {31'b0, st[1]});
      check_value("done_count", cnt0 + 32'd3, cnt1);
    end
    report_test("chain walk", err0);
  endtask

  task automatic skip_zero_length();
    int err0;
    int base;
    err0 = errors;
    base = irq_cnt;
    put_desc(32'h080, 32'h500, 32'h600, 32'd0, 32'h000);
    launch_chain(32'h080);
    wait_irqs(base + 1);
    wait_idle();
    if (timeouts == 0) begin
      check_value("irq_count", data_t'(base + 1), data_t'(irq_cnt));
      check_value("desc_num_word", DescDoneMarker, i_mem.peek(32'h088));
      check_value("dst_writes", '0, data_t'(i_mem.writes_in(32'h600, 32'h640)));
    end
    report_test("zero length", err0);
  endtask

  task automatic ignore_busy_write();
    int err0;
    int base;
    err0 = errors;
    base = irq_cnt;
    put_desc(32'h0a0, 32'h700, 32'h780, 32'd4, 32'h0b0);
    put_desc(32'h0b0, 32'h720, 32'h7c0, 32'd4, 32'h000);
    put_desc(32'h0c0, 32'h740, 32'h800, 32'd4, 32'h000); // Must never run
    fill_src(32'h700, 4);
    fill_src(32'h720, 4);
    fill_src(32'h740, 4);
    launch_chain(32'h0a0);
    launch_chain(32'h0c0); // Lands while busy
    wait_irqs(base + 2);
    wait_idle();
    if (timeouts == 0) begin
      check_value("irq_count", data_t'(base + 2), data_t'(irq_cnt));
      check_value("desc_num_word", DescDoneMarker, i_mem.peek(32'h0b8));
      check_value("ignored_num_word", 32'd4, i_mem.peek(32'h0c8));
      check_value("ignored_dst_writes", '0, data_t'(i_mem.writes_in(32'h800, 32'h810)));
    end
    report_test("busy ignore", err0);
  endtask

  initial begin
    rst         = 1'b1;
    reg_req     = '0;
    load        = '0;
    chain_armed = 1'b0;
    chk_en      = 1'b0;
    chk_name    = "";
    chk_exp     = '0;
    chk_act     = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    copy_single_desc();
    if (timeouts == 0) begin
      walk_desc_chain();
    end
    if (timeouts == 0) begin
      skip_zero_length();
    end
    if (timeouts == 0) begin
      ignore_busy_write();
    end
    tests++;
    $display("bus protocol: %0d errors", proto_errs);
    $display("Tests %0d, checks %0d, errors %0d, timeouts %0d",
             tests, checks, errors, timeouts);
    if ((errors == 0) && (timeouts == 0)) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
